// File: filelist.f
+incdir+hw
hw/riscv_pkg.sv
hw/decoder.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/decode_register.sv
hw/decode_stage.sv
sim/tb_clock.sv
sim/tb_decode_stage.sv

// File: hw/decode_register.sv
`default_nettype none

module decode_register (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  logic                    in_valid,
	input  riscv_pkg::decoded_instr in_instr,
	input  riscv_pkg::word_t        in_imm,
	input  riscv_pkg::word_t        in_rs1_data,
	input  riscv_pkg::word_t        in_rs2_data,
	input  riscv_pkg::reg_addr_t    in_rd,
	output logic                    out_valid,
	output riscv_pkg::decoded_instr out_instr,
	output riscv_pkg::word_t        out_imm,
	output riscv_pkg::word_t        out_rs1_data,
	output riscv_pkg::word_t        out_rs2_data,
	output riscv_pkg::reg_addr_t    out_rd,
	output logic                    out_bad
);

	logic in_bad;
	logic accept;

	assign in_bad = (in_instr == riscv_pkg::INSTR_BAD_INSTR);
	assign accept = in_valid && !stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			out_instr    <= riscv_pkg::decoded_instr'('0);
			out_imm      <= '0;
			out_rs1_data <= '0;
			out_rs2_data <= '0;
			out_rd       <= '0;
			out_bad      <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;	// Bubble when nothing arrives.
			if (accept) begin
				out_instr    <= in_instr;
				out_imm      <= in_imm;
				out_rs1_data <= in_rs1_data;
				out_rs2_data <= in_rs2_data;
				out_rd       <= in_rd;
				out_bad      <= in_bad;
			end
		end
	end

	// ==========================================================================
	// Checks.
	// ==========================================================================

	// A stalled edge leaves every output as it was.
	a_stall_hold: assert property (@(posedge clk)
		(!reset && stall) |=> ($stable(out_valid) && $stable(out_instr) &&
			$stable(out_imm) && $stable(out_rs1_data) && $stable(out_rs2_data) &&
			$stable(out_rd) && $stable(out_bad)))
		else $error("decode outputs moved during stall");

	// Flag and code are captured together.
	a_bad_flag: assert property (@(posedge clk) disable iff (reset)
		out_bad == (out_instr == riscv_pkg::INSTR_BAD_INSTR))
		else $error("out_bad disagrees with out_instr");

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instr_valid,
	input  riscv_pkg::word_t        instr,
	input  logic                    stall,
	input  logic                    wb_en,
	input  riscv_pkg::reg_addr_t    wb_addr,
	input  riscv_pkg::word_t        wb_data,
	output logic                    out_valid,
	output riscv_pkg::decoded_instr out_instr,
	output riscv_pkg::word_t        out_imm,
	output riscv_pkg::word_t        out_rs1_data,
	output riscv_pkg::word_t        out_rs2_data,
	output riscv_pkg::reg_addr_t    out_rd,
	output logic                    out_bad
);

	riscv_pkg::reg_addr_t rs1;
	riscv_pkg::reg_addr_t rs2;
	riscv_pkg::reg_addr_t rd;

	riscv_pkg::decoded_instr decoded;
	riscv_pkg::word_t imm;
	riscv_pkg::word_t rs1_data;
	riscv_pkg::word_t rs2_data;

	assign rd  = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// ==========================================================================
	// Combinational decode.
	// ==========================================================================

	decoder u_decoder (
		.instr   (instr),
		.decoded (decoded)
	);

	imm_gen u_imm_gen (
		.instr (instr),
		.imm   (imm)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	// Output register.
	decode_register u_decode_register (
		.clk          (clk),
		.reset        (reset),
		.stall        (stall),
		.in_valid     (instr_valid),
		.in_instr     (decoded),
		.in_imm       (imm),
		.in_rs1_data  (rs1_data),
		.in_rs2_data  (rs2_data),
		.in_rd        (rd),
		.out_valid    (out_valid),
		.out_instr    (out_instr),
		.out_imm      (out_imm),
		.out_rs1_data (out_rs1_data),
		.out_rs2_data (out_rs2_data),
		.out_rd       (out_rd),
		.out_bad      (out_bad)
	);

endmodule

`default_nettype wire

// File: hw/decoder.sv
`default_nettype none

`include "riscv_settings.svh"

module decoder (
	input  riscv_pkg::word_t        instr,
	output riscv_pkg::decoded_instr decoded
);

	riscv_pkg::opcode_t opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;

	riscv_pkg::decoded_instr comp_instr;
	riscv_pkg::decoded_instr compimm_instr;
	riscv_pkg::decoded_instr store_instr;
	riscv_pkg::decoded_instr load_instr;
	riscv_pkg::decoded_instr branch_instr;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// ==========================================================================
	// Per-group candidates.
	// ==========================================================================

	// R type.
	always_comb begin
		case (funct3)
			3'b000:  comp_instr = funct7[5] ? riscv_pkg::INSTR_SUB : riscv_pkg::INSTR_ADD;
			3'b001:  comp_instr = riscv_pkg::INSTR_SLL;
			3'b010:  comp_instr = riscv_pkg::INSTR_SLT;
			3'b011:  comp_instr = riscv_pkg::INSTR_SLTU;
			3'b100:  comp_instr = riscv_pkg::INSTR_XOR;
			3'b101:  comp_instr = funct7[5] ? riscv_pkg::INSTR_SRA : riscv_pkg::INSTR_SRL;
			3'b110:  comp_instr = riscv_pkg::INSTR_OR;
			default: comp_instr = riscv_pkg::INSTR_AND;
		endcase
	end

	// I type arithmetic; funct7 here is the upper immediate field.
	always_comb begin
		case (funct3)
			3'b000:  compimm_instr = riscv_pkg::INSTR_ADDI;
			3'b001:  compimm_instr = riscv_pkg::INSTR_SLLI;
			3'b010:  compimm_instr = riscv_pkg::INSTR_SLTI;
			3'b011:  compimm_instr = riscv_pkg::INSTR_SLTIU;
			3'b100:  compimm_instr = riscv_pkg::INSTR_XORI;
			3'b101:  compimm_instr = funct7[5] ? riscv_pkg::INSTR_SRAI : riscv_pkg::INSTR_SRLI;
			3'b110:  compimm_instr = riscv_pkg::INSTR_ORI;
			default: compimm_instr = riscv_pkg::INSTR_ANDI;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  store_instr = riscv_pkg::INSTR_SB;
			3'b001:  store_instr = riscv_pkg::INSTR_SH;
			default: store_instr = riscv_pkg::INSTR_SW;	// Unused widths fall to word.
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  load_instr = riscv_pkg::INSTR_LB;
			3'b001:  load_instr = riscv_pkg::INSTR_LH;
			3'b100:  load_instr = riscv_pkg::INSTR_LBU;
			3'b101:  load_instr = riscv_pkg::INSTR_LHU;
			default: load_instr = riscv_pkg::INSTR_LW;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b001:  branch_instr = riscv_pkg::INSTR_BNE;
			3'b100:  branch_instr = riscv_pkg::INSTR_BLT;
			3'b101:  branch_instr = riscv_pkg::INSTR_BGE;
			3'b110:  branch_instr = riscv_pkg::INSTR_BLTU;
			3'b111:  branch_instr = riscv_pkg::INSTR_BGEU;
			default: branch_instr = riscv_pkg::INSTR_BEQ;	// Also 010 and 011.
		endcase
	end

	// ==========================================================================
	// Opcode mux.
	// ==========================================================================

	generate
		if (`RISCV_M_CORE) begin : g_rv32im
			riscv_pkg::decoded_instr multdiv_instr;

			always_comb begin
				case (funct3)
					3'b000:  multdiv_instr = riscv_pkg::INSTR_MUL;
					3'b001:  multdiv_instr = riscv_pkg::INSTR_MULH;
					3'b010:  multdiv_instr = riscv_pkg::INSTR_MULHSU;
					3'b011:  multdiv_instr = riscv_pkg::INSTR_MULHU;
					3'b100:  multdiv_instr = riscv_pkg::INSTR_DIV;
					3'b101:  multdiv_instr = riscv_pkg::INSTR_DIVU;
					3'b110:  multdiv_instr = riscv_pkg::INSTR_REM;
					default: multdiv_instr = riscv_pkg::INSTR_REMU;
				endcase
			end

			always_comb begin
				case (opcode)
					riscv_pkg::OPCODE_COMP:    decoded = funct7[0] ? multdiv_instr : comp_instr;
					riscv_pkg::OPCODE_COMPIMM: decoded = compimm_instr;
					riscv_pkg::OPCODE_STORE:   decoded = store_instr;
					riscv_pkg::OPCODE_LOAD:    decoded = load_instr;
					riscv_pkg::OPCODE_BRANCH:  decoded = branch_instr;
					riscv_pkg::OPCODE_JALR:    decoded = riscv_pkg::INSTR_JALR;
					riscv_pkg::OPCODE_JAL:     decoded = riscv_pkg::INSTR_JAL;
					riscv_pkg::OPCODE_AUIPC:   decoded = riscv_pkg::INSTR_AUIPC;
					riscv_pkg::OPCODE_LUI:     decoded = riscv_pkg::INSTR_LUI;
					default:                   decoded = riscv_pkg::INSTR_BAD_INSTR;
				endcase
			end
		end else begin : g_rv32i
			always_comb begin
				case (opcode)
					riscv_pkg::OPCODE_COMP:    decoded = comp_instr;
					riscv_pkg::OPCODE_COMPIMM: decoded = compimm_instr;
					riscv_pkg::OPCODE_STORE:   decoded = store_instr;
					riscv_pkg::OPCODE_LOAD:    decoded = load_instr;
					riscv_pkg::OPCODE_BRANCH:  decoded = branch_instr;
					riscv_pkg::OPCODE_JALR:    decoded = riscv_pkg::INSTR_JALR;
					riscv_pkg::OPCODE_JAL:     decoded = riscv_pkg::INSTR_JAL;
					riscv_pkg::OPCODE_AUIPC:   decoded = riscv_pkg::INSTR_AUIPC;
					riscv_pkg::OPCODE_LUI:     decoded = riscv_pkg::INSTR_LUI;
					default:                   decoded = riscv_pkg::INSTR_BAD_INSTR;
				endcase
			end
		end
	endgenerate

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`default_nettype none

module imm_gen (
	input  riscv_pkg::word_t instr,
	output riscv_pkg::word_t imm
);

	riscv_pkg::opcode_t opcode;
	riscv_pkg::word_t imm_i;
	riscv_pkg::word_t imm_s;
	riscv_pkg::word_t imm_b;
	riscv_pkg::word_t imm_u;
	riscv_pkg::word_t imm_j;

	assign opcode = instr[6:0];

	// ==========================================================================
	// Format fields. Bit 31 is always the sign.
	// ==========================================================================

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

	// Branch offsets are in half words.
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opcode)
			riscv_pkg::OPCODE_COMPIMM,
			riscv_pkg::OPCODE_LOAD,
			riscv_pkg::OPCODE_JALR:   imm = imm_i;
			riscv_pkg::OPCODE_STORE:  imm = imm_s;
			riscv_pkg::OPCODE_BRANCH: imm = imm_b;
			riscv_pkg::OPCODE_LUI,
			riscv_pkg::OPCODE_AUIPC:  imm = imm_u;
			riscv_pkg::OPCODE_JAL:    imm = imm_j;
			default:                  imm = '0;	// R type and bad opcodes.
		endcase
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

`include "riscv_settings.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 reset,
	input  riscv_pkg::reg_addr_t rs1,
	input  riscv_pkg::reg_addr_t rs2,
	output riscv_pkg::word_t     rs1_data,
	output riscv_pkg::word_t     rs2_data,
	input  logic                 wb_en,
	input  riscv_pkg::reg_addr_t wb_addr,
	input  riscv_pkg::word_t     wb_data
);

	// Entry 0 is cleared by reset and never written.
	riscv_pkg::word_t regs [0:`REG_COUNT-1];

	logic wr_ok;

	assign wr_ok = wb_en && (wb_addr != '0);	// Drop writes to x0.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// No bypass; a write shows up after its edge.
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// ==========================================================================
	// Checks.
	// ==========================================================================

	// x0 stays zero across any history of writes.
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)))
		else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: hw/riscv_pkg.sv
`default_nettype none

`include "riscv_settings.svh"

package riscv_pkg;

	// ==========================================================================
	// Vector types.
	// ==========================================================================

	localparam int DCODE_WIDTH = 7;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

	// ==========================================================================
	// Major opcodes.
	// ==========================================================================

	localparam opcode_t OPCODE_COMP    = 7'b0110011;	// R type.
	localparam opcode_t OPCODE_COMPIMM = 7'b0010011;
	localparam opcode_t OPCODE_LOAD    = 7'b0000011;
	localparam opcode_t OPCODE_STORE   = 7'b0100011;
	localparam opcode_t OPCODE_BRANCH  = 7'b1100011;
	localparam opcode_t OPCODE_JAL     = 7'b1101111;
	localparam opcode_t OPCODE_JALR    = 7'b1100111;
	localparam opcode_t OPCODE_LUI     = 7'b0110111;
	localparam opcode_t OPCODE_AUIPC   = 7'b0010111;

	// ==========================================================================
	// Decoded instruction codes.
	// ==========================================================================

	typedef enum logic [DCODE_WIDTH-1:0] {
		// Register-register.
		INSTR_ADD = 7'd0,
		INSTR_SUB,
		INSTR_SLL,
		INSTR_SLT,
		INSTR_SLTU,
		INSTR_XOR,
		INSTR_SRL,
		INSTR_SRA,
		INSTR_OR,
		INSTR_AND,
		// Register-immediate.
		INSTR_ADDI,
		INSTR_SLLI,
		INSTR_SLTI,
		INSTR_SLTIU,
		INSTR_XORI,
		INSTR_SRLI,
		INSTR_SRAI,
		INSTR_ORI,
		INSTR_ANDI,
		// Memory.
		INSTR_SB,
		INSTR_SH,
		INSTR_SW,
		INSTR_LB,
		INSTR_LH,
		INSTR_LW,
		INSTR_LBU,
		INSTR_LHU,
		// Control flow and upper immediates.
		INSTR_BEQ,
		INSTR_BNE,
		INSTR_BLT,
		INSTR_BGE,
		INSTR_BLTU,
		INSTR_BGEU,
		INSTR_JALR,
		INSTR_JAL,
		INSTR_AUIPC,
		INSTR_LUI,
		// M extension.
		INSTR_MUL,
		INSTR_MULH,
		INSTR_MULHSU,
		INSTR_MULHU,
		INSTR_DIV,
		INSTR_DIVU,
		INSTR_REM,
		INSTR_REMU,
		INSTR_BAD_INSTR
	} decoded_instr;

endpackage

`default_nettype wire

// File: hw/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// ==========================================================================
// Core configuration.
// ==========================================================================

// Data and instruction width.
`define WORD_WIDTH 32

// Major opcode field in bits 6:0.
`define OPCODE_WIDTH 7

`define REG_COUNT 32	// x0 to x31.

// 1 adds the M extension (multiply and divide) to the decoder.
`define RISCV_M_CORE 1

`endif

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;	// Period 100.
	end

	// Reset spans the first 8 rising edges.
	initial begin
		reset = 1'b1;
		repeat (8)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/tb_decode_stage.sv
`default_nettype none

`include "riscv_settings.svh"

module tb_decode_stage;

	localparam int RUN_CYCLES = 4000;
	localparam int PERIOD = 100;
	localparam time LIMIT = (8 + `REG_COUNT + RUN_CYCLES + 200) * PERIOD;

	localparam riscv_pkg::opcode_t VALID_OPS [9] = '{riscv_pkg::OPCODE_COMP,
		riscv_pkg::OPCODE_COMPIMM, riscv_pkg::OPCODE_LOAD, riscv_pkg::OPCODE_STORE,
		riscv_pkg::OPCODE_BRANCH, riscv_pkg::OPCODE_JAL, riscv_pkg::OPCODE_JALR,
		riscv_pkg::OPCODE_LUI, riscv_pkg::OPCODE_AUIPC};

	// Members of each group by funct3.
	localparam riscv_pkg::decoded_instr R_OPS [8] = '{riscv_pkg::INSTR_ADD,
		riscv_pkg::INSTR_SLL, riscv_pkg::INSTR_SLT, riscv_pkg::INSTR_SLTU,
		riscv_pkg::INSTR_XOR, riscv_pkg::INSTR_SRL, riscv_pkg::INSTR_OR,
		riscv_pkg::INSTR_AND};
	localparam riscv_pkg::decoded_instr I_OPS [8] = '{riscv_pkg::INSTR_ADDI,
		riscv_pkg::INSTR_SLLI, riscv_pkg::INSTR_SLTI, riscv_pkg::INSTR_SLTIU,
		riscv_pkg::INSTR_XORI, riscv_pkg::INSTR_SRLI, riscv_pkg::INSTR_ORI,
		riscv_pkg::INSTR_ANDI};
	localparam riscv_pkg::decoded_instr M_OPS [8] = '{riscv_pkg::INSTR_MUL,
		riscv_pkg::INSTR_MULH, riscv_pkg::INSTR_MULHSU, riscv_pkg::INSTR_MULHU,
		riscv_pkg::INSTR_DIV, riscv_pkg::INSTR_DIVU, riscv_pkg::INSTR_REM, riscv_pkg::INSTR_REMU};
	localparam riscv_pkg::decoded_instr LOAD_OPS [8] = '{riscv_pkg::INSTR_LB,
		riscv_pkg::INSTR_LH, riscv_pkg::INSTR_LW, riscv_pkg::INSTR_LW,
		riscv_pkg::INSTR_LBU, riscv_pkg::INSTR_LHU, riscv_pkg::INSTR_LW,
		riscv_pkg::INSTR_LW};
	localparam riscv_pkg::decoded_instr STORE_OPS [8] = '{riscv_pkg::INSTR_SB,
		riscv_pkg::INSTR_SH, riscv_pkg::INSTR_SW, riscv_pkg::INSTR_SW,
		riscv_pkg::INSTR_SW, riscv_pkg::INSTR_SW, riscv_pkg::INSTR_SW,
		riscv_pkg::INSTR_SW};
	localparam riscv_pkg::decoded_instr BRANCH_OPS [8] = '{riscv_pkg::INSTR_BEQ,
		riscv_pkg::INSTR_BNE, riscv_pkg::INSTR_BEQ, riscv_pkg::INSTR_BEQ,
		riscv_pkg::INSTR_BLT, riscv_pkg::INSTR_BGE, riscv_pkg::INSTR_BLTU,
		riscv_pkg::INSTR_BGEU};

	logic clk;
	logic reset;
	logic instr_valid;
	riscv_pkg::word_t instr;
	logic stall;
	logic wb_en;
	riscv_pkg::reg_addr_t wb_addr;
	riscv_pkg::word_t wb_data;
	logic out_valid;
	riscv_pkg::decoded_instr out_instr;
	riscv_pkg::word_t out_imm;
	riscv_pkg::word_t out_rs1_data;
	riscv_pkg::word_t out_rs2_data;
	riscv_pkg::reg_addr_t out_rd;
	logic out_bad;

	// Model state.
	riscv_pkg::word_t model_regs [`REG_COUNT];
	logic exp_valid;
	riscv_pkg::decoded_instr exp_instr;
	riscv_pkg::word_t exp_imm;
	riscv_pkg::word_t exp_rs1_data;
	riscv_pkg::word_t exp_rs2_data;
	riscv_pkg::reg_addr_t exp_rd;
	logic exp_bad;
	logic [31:0] lfsr;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	decode_stage dut (.*);

	// ==========================================================================
	// Random source and reference model.
	// ==========================================================================

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic opcode_listed(input riscv_pkg::opcode_t op);
		foreach (VALID_OPS[k])
			if (VALID_OPS[k] == op)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic riscv_pkg::decoded_instr expected_code(input riscv_pkg::word_t w);
		logic [2:0] f3;
		logic alt;
		logic muldiv;
		riscv_pkg::decoded_instr code;
		f3 = w[14:12];
		alt = w[30];	// funct7 bit 5.
		muldiv = (`RISCV_M_CORE != 0) && w[25];
		case (w[6:0])
			riscv_pkg::OPCODE_COMP: begin
				code = muldiv ? M_OPS[f3] : R_OPS[f3];
				if (!muldiv && alt && f3 == 3'd0)
					code = riscv_pkg::INSTR_SUB;
				if (!muldiv && alt && f3 == 3'd5)
					code = riscv_pkg::INSTR_SRA;
			end
			riscv_pkg::OPCODE_COMPIMM:
				code = (alt && f3 == 3'd5) ? riscv_pkg::INSTR_SRAI : I_OPS[f3];
			riscv_pkg::OPCODE_LOAD:   code = LOAD_OPS[f3];
			riscv_pkg::OPCODE_STORE:  code = STORE_OPS[f3];
			riscv_pkg::OPCODE_BRANCH: code = BRANCH_OPS[f3];
			riscv_pkg::OPCODE_JAL:    code = riscv_pkg::INSTR_JAL;
			riscv_pkg::OPCODE_JALR:   code = riscv_pkg::INSTR_JALR;
			riscv_pkg::OPCODE_LUI:    code = riscv_pkg::INSTR_LUI;
			riscv_pkg::OPCODE_AUIPC:  code = riscv_pkg::INSTR_AUIPC;
			default:                  code = riscv_pkg::INSTR_BAD_INSTR;
		endcase
		return code;
	endfunction

	// Signed fields widen by sign extension in the casts.
	function automatic riscv_pkg::word_t expected_imm(input riscv_pkg::word_t w);
		logic signed [11:0] i_field;
		logic signed [11:0] s_field;
		logic signed [12:0] b_field;
		logic signed [20:0] j_field;
		riscv_pkg::word_t imm;
		i_field = w[31:20];
		s_field = {w[31:25], w[11:7]};
		b_field = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		j_field = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		case (w[6:0])
			riscv_pkg::OPCODE_COMPIMM,
			riscv_pkg::OPCODE_LOAD,
			riscv_pkg::OPCODE_JALR:   imm = riscv_pkg::word_t'(i_field);
			riscv_pkg::OPCODE_STORE:  imm = riscv_pkg::word_t'(s_field);
			riscv_pkg::OPCODE_BRANCH: imm = riscv_pkg::word_t'(b_field);
			riscv_pkg::OPCODE_JAL:    imm = riscv_pkg::word_t'(j_field);
			riscv_pkg::OPCODE_LUI,
			riscv_pkg::OPCODE_AUIPC:  imm = w & 32'hffff_f000;
			default:                  imm = '0;
		endcase
		return imm;
	endfunction

	function automatic riscv_pkg::word_t random_instr();
		riscv_pkg::opcode_t op;
		riscv_pkg::word_t w;
		if (random_bits(3) == 0) begin
			do
				op = riscv_pkg::opcode_t'(random_bits(7));
			while (opcode_listed(op));
		end else begin
			op = VALID_OPS[random_bits(4) % 9];
		end
		w = random_bits(25) << 7;
		w[6:0] = op;
		return w;
	endfunction

	task automatic model_edge();
		if (!stall) begin
			exp_valid = instr_valid;
			if (instr_valid) begin
				exp_instr = expected_code(instr);
				exp_imm = expected_imm(instr);
				exp_rs1_data = model_regs[instr[19:15]];
				exp_rs2_data = model_regs[instr[24:20]];
				exp_rd = instr[11:7];
				exp_bad = !opcode_listed(instr[6:0]);
			end
		end
		if (wb_en && wb_addr != '0)
			model_regs[wb_addr] = wb_data;	// After the reads.
	endtask

	// ==========================================================================
	// Compare tasks.
	// ==========================================================================

	task automatic stop_on_error();
		$display("TEST FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_code(input riscv_pkg::decoded_instr got,
		input riscv_pkg::decoded_instr exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_word(input riscv_pkg::word_t got, input riscv_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input riscv_pkg::reg_addr_t got,
		input riscv_pkg::reg_addr_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_outputs();
		check_bit(out_valid, exp_valid, "out_valid");
		check_bit(out_bad, exp_bad, "out_bad");
		check_code(out_instr, exp_instr, "out_instr");
		check_word(out_imm, exp_imm, "out_imm");
		check_word(out_rs1_data, exp_rs1_data, "out_rs1_data");
		check_word(out_rs2_data, exp_rs2_data, "out_rs2_data");
		check_addr(out_rd, exp_rd, "out_rd");
	endtask

	// Model the edge, drive the next inputs, check at the falling edge.
	task automatic step(input riscv_pkg::word_t n_instr, input logic n_valid,
		input logic n_stall, input logic n_wb_en, input riscv_pkg::reg_addr_t n_wb_addr,
		input riscv_pkg::word_t n_wb_data);
		@(posedge clk);
		model_edge();
		instr <= n_instr;
		instr_valid <= n_valid;
		stall <= n_stall;
		wb_en <= n_wb_en;
		wb_addr <= n_wb_addr;
		wb_data <= n_wb_data;
		@(negedge clk);
		check_outputs();
	endtask

	// ==========================================================================
	// Stimulus.
	// ==========================================================================

	initial begin
		riscv_pkg::word_t nxt;
		riscv_pkg::reg_addr_t waddr;
		riscv_pkg::word_t wdata;
		logic n_valid;
		logic n_stall;
		logic n_wb_en;
		lfsr = 32'h1275f294;
		instr_valid = 1'b0;
		instr = '0;
		stall = 1'b0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		foreach (model_regs[k])
			model_regs[k] = '0;
		exp_valid = 1'b0;
		exp_instr = riscv_pkg::decoded_instr'(0);
		exp_imm = '0;
		exp_rs1_data = '0;
		exp_rs2_data = '0;
		exp_rd = '0;
		exp_bad = 1'b0;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		check_outputs();
		// Every index read once while all registers are still zero.
		for (int i = 0; i < `REG_COUNT; i++)
			step({7'b0, 5'(31 - i), 5'(i), 3'b0, 5'(i), riscv_pkg::OPCODE_COMP},
				1'b1, 1'b0, 1'b0, '0, '0);
		for (int n = 0; n < RUN_CYCLES; n++) begin
			nxt = random_instr();
			n_valid = random_bits(2) != 0;
			n_stall = random_bits(8) % 6 == 0;
			n_wb_en = random_bits(1) != 0;
			waddr = riscv_pkg::reg_addr_t'(random_bits(5));
			if (random_bits(2) == 0)
				waddr = nxt[19:15];	// Write races the read of rs1.
			wdata = random_bits(32);
			step(nxt, n_valid, n_stall, n_wb_en, waddr, wdata);
		end
		step('0, 1'b0, 1'b0, 1'b0, '0, '0);
		$display("TEST OK");
		$finish;
	end

	initial begin
		#(LIMIT);
		$display("Run timed out at %0t before the test sequence finished.", $time);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
